//--- tb.f
+incdir+verification
src/fetch_pkg.sv
src/target_buffer.sv
src/direction_predictor.sv
src/return_stack.sv
src/fetch_sequencer.sv
src/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
  -f tb.f -o fetch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

//--- verification/fetch_model.svh
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

logic                    m_valid;
fetch_pkg::addr_t        m_ip;
fetch_pkg::hist_t        m_hist;
fetch_pkg::ctr_t         m_ctr [3][256];
logic                    m_bv [64][2];
logic [21:0]             m_btag [64][2];   // address bits 31:10
fetch_pkg::addr_t        m_btgt [64][2];
fetch_pkg::branch_kind_e m_bkind [64][2];
fetch_pkg::addr_t        m_ras [8];
logic [2:0]              m_sp;

function automatic logic [7:0] ctr_index(input int t, input fetch_pkg::addr_t a,
                                         input logic slot, input fetch_pkg::hist_t h);
  logic [7:0] base;
  base = {a[10:4], slot};
  if (t == 0) return base;
  if (t == 1) return base ^ h;
  return {4'b0000, a[6:4], slot} ^ h;
endfunction

function automatic logic slot_takes(input fetch_pkg::addr_t a, input int s);
  int votes;
  logic hit;
  votes = 0;
  hit = m_bv[a[9:4]][s] && (m_btag[a[9:4]][s] == a[31:10]);
  for (int t = 0; t < 3; t++)
    if (m_ctr[t][ctr_index(t, a, 1'(s), m_hist)][1]) votes++;
  return hit && (m_bkind[a[9:4]][s] != fetch_pkg::kind_cond || votes >= 2);
endfunction

task automatic model_reset();
  m_valid = 1'b0;
  m_ip    = fetch_pkg::reset_vector;
  m_hist  = '0;
  m_sp    = '0;
  for (int t = 0; t < 3; t++)
    for (int i = 0; i < 256; i++) m_ctr[t][i] = 2'b01;
  for (int s = 0; s < 64; s++) begin
    m_bv[s][0] = 1'b0;
    m_bv[s][1] = 1'b0;
  end
  for (int i = 0; i < 8; i++) m_ras[i] = '0;
endtask

task automatic model_step(input fetch_pkg::retire_upd_t u, input logic ready);
  logic tk;
  int sl;
  fetch_pkg::addr_t seq;
  fetch_pkg::addr_t nxt;
  fetch_pkg::addr_t tgt;
  fetch_pkg::branch_kind_e kd;
  logic [7:0] idx [3];
  tk  = slot_takes(m_ip, 0) || slot_takes(m_ip, 1);
  sl  = slot_takes(m_ip, 0) ? 0 : 1;
  seq = m_ip + 32'd16;
  nxt = seq;
  tgt = m_btgt[m_ip[9:4]][sl];  // lookup sees the buffer before this write
  kd  = m_bkind[m_ip[9:4]][sl];
  for (int t = 0; t < 3; t++) idx[t] = ctr_index(t, u.src, u.slot, u.hist);
  if (u.valid) begin
    m_bv[u.src[9:4]][u.slot]    = 1'b1;
    m_btag[u.src[9:4]][u.slot]  = u.src[31:10];
    m_btgt[u.src[9:4]][u.slot]  = u.target;
    m_bkind[u.src[9:4]][u.slot] = u.kind;
    if (u.kind == fetch_pkg::kind_cond)
      for (int t = 0; t < 3; t++) begin
        if (u.taken && m_ctr[t][idx[t]] != 2'b11) m_ctr[t][idx[t]] += 2'd1;
        if (!u.taken && m_ctr[t][idx[t]] != 2'b00) m_ctr[t][idx[t]] -= 2'd1;
      end
  end
  if (u.valid && u.mispredict) begin
    m_ip   = (u.taken ? u.target : u.src + 32'd16) & 32'hffff_fff0;
    m_hist = {u.hist[6:0], u.taken};
  end else if (m_valid && ready) begin
    if (tk) begin
      nxt = tgt;
      if (kd == fetch_pkg::kind_ret) begin
        nxt  = m_ras[m_sp];
        m_sp = m_sp - 3'd1;
      end else if (kd == fetch_pkg::kind_call) begin
        m_sp        = m_sp + 3'd1;
        m_ras[m_sp] = seq;
      end
    end
    m_ip   = nxt & 32'hffff_fff0;
    m_hist = {m_hist[6:0], tk};
  end
  m_valid = 1'b1;
endtask

`endif

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int test_cycles [6] = '{40, 80, 150, 200, 200, 200};
  localparam int total_cycles = 10 + 40 + 80 + 150 + 200 + 200 + 200;

  logic                   clk;
  logic                   rst;
  logic                   fetch_ready;
  fetch_pkg::retire_upd_t upd;
  fetch_pkg::fetch_out_t  fetch;
  logic                   fetch_valid;

  integer seed;
  int     errors;
  int     checks;

  `include "fetch_model.svh"

  fetch_top DUT (
    .clk         (clk),
    .rst         (rst),
    .upd         (upd),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .fetch_valid (fetch_valid)
  );

  bind fetch_top fetch_assertions chk (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_outputs();
    logic exp_taken;
    logic exp_slot;
    exp_taken = slot_takes(m_ip, 0) || slot_takes(m_ip, 1);
    exp_slot  = exp_taken && !slot_takes(m_ip, 0);
    checks++;
    if (fetch_valid !== m_valid) begin
      $display("Error at %0t: fetch_valid %b expected %b", $time, fetch_valid, m_valid);
      errors++;
    end
    if (m_valid && fetch.addr !== m_ip) begin
      $display("Error at %0t: block address %h expected %h", $time, fetch.addr, m_ip);
      errors++;
    end
    if (m_valid && (fetch.taken !== exp_taken || fetch.slot !== exp_slot)) begin
      $display("Error at %0t: taken/slot %b/%b expected %b/%b", $time,
               fetch.taken, fetch.slot, exp_taken, exp_slot);
      errors++;
    end
    if (m_valid && fetch.hist !== m_hist) begin
      $display("Error at %0t: history %h expected %h", $time, fetch.hist, m_hist);
      errors++;
    end
  endtask

  // modes: 0 free run, 1 stalls, 2 jumps, 3 conds, 4 calls/rets, 5 mispredicts
  task automatic drive(input int mode);
    fetch_pkg::retire_upd_t u;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    u = '0;
    r = $random(seed);
    a = $random(seed);
    b = $random(seed);
    if (mode >= 2 && r[1:0] == 2'b00) begin
      u.valid  = 1'b1;
      u.src    = fetch_pkg::reset_vector + {25'd0, a[2:0], 4'h0};
      u.slot   = a[3];
      u.target = fetch_pkg::reset_vector + {24'd0, b[3:0], b[7:4]}; // low bits get masked
      u.taken  = 1'b1;
      u.hist   = m_hist;
      case (mode)
        2: u.kind = fetch_pkg::kind_jump;
        3: u.kind = fetch_pkg::kind_cond;
        4: u.kind = b[8] ? fetch_pkg::kind_call : fetch_pkg::kind_ret;
        default: u.kind = fetch_pkg::branch_kind_e'(b[9:8]);
      endcase
      if (u.kind == fetch_pkg::kind_cond) u.taken = b[10];
      u.mispredict = (mode == 5) ? b[11] : (b[13:11] == 3'b000);
    end
    upd <= u;
    if (mode == 0) fetch_ready <= 1'b1;
    else if (mode == 1) fetch_ready <= (r[5:4] == 2'b00);
    else fetch_ready <= (r[7:5] != 3'b000);
  endtask

  task automatic run_test(input int id, input string name, input int mode);
    int e0;
    int c0;
    e0 = errors;
    c0 = checks;
    for (int i = 0; i < test_cycles[id-1]; i++) begin
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      model_step(upd, fetch_ready);
      drive(mode);
    end
    $display("test %0d %s: %0d checks, %0d errors", id, name, checks - c0, errors - e0);
  endtask

  initial begin
    seed        = 32'hc6cb816e;
    rst         = 1'b1;
    fetch_ready = 1'b0;
    upd         = '0;
    errors      = 0;
    checks      = 0;
    model_reset();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    run_test(1, "sequential fetch", 0);
    run_test(2, "stalls", 1);
    run_test(3, "jump targets", 2);
    run_test(4, "conditional majority", 3);
    run_test(5, "calls and returns", 4);
    run_test(6, "mispredict redirect", 5);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(total_cycles * 4 + 200);
    $display("timeout: the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verification/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   fetch_ready,
  input fetch_pkg::retire_upd_t upd,
  input fetch_pkg::fetch_out_t  fetch,
  input logic                   fetch_valid
);

  // reset clears the valid flag on the following edge
  reset_clears_valid: assert property (@(posedge clk) rst |=> !fetch_valid)
    else $error("fetch_valid high after a reset cycle");

  // a stalled block keeps its address and history
  stall_holds_block: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && !fetch_ready && !(upd.valid && upd.mispredict)
      |=> $stable(fetch.addr) && $stable(fetch.hist))
    else $error("fetch block changed during a stall");

  block_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_valid |-> fetch.addr[3:0] == 4'h0)
    else $error("fetch block address not 16-byte aligned");

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::retire_upd_t upd,
  input  logic                   fetch_ready,
  output fetch_pkg::fetch_out_t  fetch,
  output logic                   fetch_valid
);

  fetch_pkg::addr_t   block_addr;
  fetch_pkg::tb_hit_t hit;
  logic [1:0]         slot_taken;
  fetch_pkg::hist_t   hist;
  fetch_pkg::addr_t   ras_top;
  fetch_pkg::addr_t   push_addr;
  logic               accept;
  logic               taken;
  logic               push;
  logic               pop;

  fetch_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .fetch_ready (fetch_ready),
    .hit         (hit),
    .slot_taken  (slot_taken),
    .hist        (hist),
    .ras_top     (ras_top),
    .upd         (upd),
    .block_addr  (block_addr),
    .accept      (accept),
    .taken       (taken),
    .push        (push),
    .pop         (pop),
    .push_addr   (push_addr),
    .fetch       (fetch),
    .fetch_valid (fetch_valid)
  );

  target_buffer u_btb (
    .clk        (clk),
    .rst        (rst),
    .block_addr (block_addr),
    .upd        (upd),
    .hit        (hit)
  );

  direction_predictor u_dir (
    .clk        (clk),
    .rst        (rst),
    .block_addr (block_addr),
    .accept     (accept),
    .taken      (taken),
    .upd        (upd),
    .slot_taken (slot_taken),
    .hist       (hist)
  );

  return_stack u_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .pop       (pop),
    .push_addr (push_addr),
    .top       (ras_top)
  );

endmodule

//--- src/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_ready,
  input  fetch_pkg::tb_hit_t     hit,
  input  logic [1:0]             slot_taken,
  input  fetch_pkg::hist_t       hist,
  input  fetch_pkg::addr_t       ras_top,
  input  fetch_pkg::retire_upd_t upd,
  output fetch_pkg::addr_t       block_addr,
  output logic                   accept,
  output logic                   taken,
  output logic                   push,
  output logic                   pop,
  output fetch_pkg::addr_t       push_addr,
  output fetch_pkg::fetch_out_t  fetch,
  output logic                   fetch_valid
);

  fetch_pkg::addr_t ip_q;
  logic             valid_q;

  logic [1:0]              take;
  logic                    sel_slot;
  fetch_pkg::branch_kind_e sel_kind;
  fetch_pkg::addr_t        sel_target;
  fetch_pkg::addr_t        seq_ip;
  fetch_pkg::addr_t        next_ip;
  fetch_pkg::addr_t        redirect_ip;
  logic                    redirect;

  // conditionals need the predictor, everything else is always taken
  always_comb begin
    for (int s = 0; s < 2; s++)
      take[s] = hit.hit[s] && (hit.kind[s] != fetch_pkg::kind_cond || slot_taken[s]);
  end

  assign taken      = |take;
  assign sel_slot   = !take[0]; // slot 0 wins
  assign sel_kind   = hit.kind[sel_slot];
  assign sel_target = hit.target[sel_slot];
  assign seq_ip     = ip_q + fetch_pkg::block_step;

  always_comb begin
    next_ip = seq_ip;
    if (taken) begin
      if (sel_kind == fetch_pkg::kind_ret)
        next_ip = ras_top;
      else
        next_ip = sel_target;
    end
  end

  assign redirect    = upd.valid && upd.mispredict;
  assign redirect_ip = upd.taken ? upd.target : upd.src + fetch_pkg::block_step;

  // mispredict redirect wins over a handshake in the same cycle
  assign accept    = fetch_valid && fetch_ready && !redirect;
  assign push      = accept && taken && (sel_kind == fetch_pkg::kind_call);
  assign pop       = accept && taken && (sel_kind == fetch_pkg::kind_ret);
  assign push_addr = seq_ip;

  assign block_addr  = ip_q;
  assign fetch_valid = valid_q;

  always_comb begin
    fetch.addr  = ip_q;
    fetch.taken = taken;
    fetch.slot  = taken && sel_slot;
    fetch.hist  = hist;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= fetch_pkg::reset_vector;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (redirect)
        ip_q <= redirect_ip & fetch_pkg::block_mask;
      else if (accept)
        ip_q <= next_ip & fetch_pkg::block_mask; // targets land inside a block
    end
  end

endmodule

//--- src/return_stack.sv
`timescale 1ns/1ps

module return_stack (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic             pop,
  input  fetch_pkg::addr_t push_addr,
  output fetch_pkg::addr_t top
);

  fetch_pkg::addr_t    stack_q [fetch_pkg::ras_depth];
  fetch_pkg::ras_ptr_t ptr_q;
  fetch_pkg::ras_ptr_t ptr_up;
  fetch_pkg::ras_ptr_t ptr_down;

  // pointer wraps, so a deep call chain overwrites the oldest return
  assign ptr_up   = ptr_q + 1'b1;
  assign ptr_down = ptr_q - 1'b1;
  assign top      = stack_q[ptr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
      for (int i = 0; i < fetch_pkg::ras_depth; i++)
        stack_q[i] <= '0;
    end else if (push) begin
      stack_q[ptr_up] <= push_addr;
      ptr_q           <= ptr_up;
    end else if (pop) begin
      ptr_q <= ptr_down; // underflow just exposes old contents
    end
  end

endmodule

//--- src/direction_predictor.sv
`timescale 1ns/1ps

module direction_predictor (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::addr_t       block_addr,
  input  logic                   accept,
  input  logic                   taken,
  input  fetch_pkg::retire_upd_t upd,
  output logic [1:0]             slot_taken,
  output fetch_pkg::hist_t       hist
);

  localparam int entries = 2 ** fetch_pkg::table_index_w;
  localparam int quorum  = fetch_pkg::ctr_tables / 2 + 1;

  fetch_pkg::ctr_t    tables_q [fetch_pkg::ctr_tables][entries];
  fetch_pkg::hist_t   hist_q;
  fetch_pkg::tindex_t rd_idx [fetch_pkg::ctr_tables][2];
  fetch_pkg::tindex_t upd_idx [fetch_pkg::ctr_tables];
  logic [1:0][fetch_pkg::ctr_tables-1:0] vote;
  logic train;

  // A: block bits plus slot, B: same xor history, C: low block bits xor history
  function automatic fetch_pkg::tindex_t table_index(input int t, input fetch_pkg::addr_t a,
                                                     input logic slot, input fetch_pkg::hist_t h);
    fetch_pkg::tindex_t base;
    fetch_pkg::tindex_t short_base;
    base       = {a[fetch_pkg::offset_w +: fetch_pkg::table_index_w - 1], slot};
    short_base = fetch_pkg::tindex_t'({a[fetch_pkg::offset_w +: 3], slot});
    case (t)
      0:       return base;
      1:       return base ^ h;
      default: return short_base ^ h;
    endcase
  endfunction

  function automatic fetch_pkg::ctr_t ctr_next(input fetch_pkg::ctr_t c, input logic up);
    if (up)
      return (c == 2'b11) ? c : c + 2'd1;
    return (c == 2'b00) ? c : c - 2'd1;
  endfunction

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      for (int t = 0; t < fetch_pkg::ctr_tables; t++) begin
        rd_idx[t][s] = table_index(t, block_addr, 1'(s), hist_q);
        vote[s][t]   = tables_q[t][rd_idx[t][s]][1];
      end
      slot_taken[s] = $countones(vote[s]) >= quorum;
    end
  end

  // training uses the history seen when the branch was fetched
  always_comb begin
    for (int t = 0; t < fetch_pkg::ctr_tables; t++)
      upd_idx[t] = table_index(t, upd.src, upd.slot, upd.hist);
  end

  assign train = upd.valid && (upd.kind == fetch_pkg::kind_cond);
  assign hist  = hist_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < fetch_pkg::ctr_tables; t++) begin
        for (int i = 0; i < entries; i++)
          tables_q[t][i] <= fetch_pkg::ctr_init;
      end
    end else if (train) begin
      for (int t = 0; t < fetch_pkg::ctr_tables; t++)
        tables_q[t][upd_idx[t]] <= ctr_next(tables_q[t][upd_idx[t]], upd.taken);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hist_q <= '0;
    end else if (upd.valid && upd.mispredict) begin
      hist_q <= {upd.hist[fetch_pkg::hist_w-2:0], upd.taken}; // replay the real outcome
    end else if (accept) begin
      hist_q <= {hist_q[fetch_pkg::hist_w-2:0], taken};
    end
  end

endmodule

//--- src/target_buffer.sv
`timescale 1ns/1ps

module target_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::addr_t      block_addr,
  input  fetch_pkg::retire_upd_t upd,
  output fetch_pkg::tb_hit_t    hit
);

  fetch_pkg::tb_entry_t entry_q [fetch_pkg::tb_sets][2];

  fetch_pkg::tb_set_t   rd_set;
  fetch_pkg::tb_tag_t   rd_tag;
  fetch_pkg::tb_set_t   wr_set;
  fetch_pkg::tb_entry_t wr_entry;

  assign rd_set = block_addr[fetch_pkg::offset_w +: fetch_pkg::set_w];
  assign rd_tag = block_addr[fetch_pkg::tag_lsb +: fetch_pkg::tag_w];
  assign wr_set = upd.src[fetch_pkg::offset_w +: fetch_pkg::set_w];

  always_comb begin
    wr_entry.valid  = 1'b1;
    wr_entry.tag    = upd.src[fetch_pkg::tag_lsb +: fetch_pkg::tag_w];
    wr_entry.target = upd.target;
    wr_entry.kind   = upd.kind;
  end

  // both slots of the set are looked up in parallel
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hit.hit[w]    = entry_q[rd_set][w].valid && (entry_q[rd_set][w].tag == rd_tag);
      hit.kind[w]   = entry_q[rd_set][w].kind;
      hit.target[w] = entry_q[rd_set][w].target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < fetch_pkg::tb_sets; s++) begin
        entry_q[s][0].valid <= 1'b0;
        entry_q[s][1].valid <= 1'b0;
      end
    end else if (upd.valid) begin
      entry_q[wr_set][upd.slot] <= wr_entry; // slot 1 is the upper 8 bytes
    end
  end

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

  localparam int addr_w        = 32;
  localparam int block_bytes   = 16;
  localparam int tb_sets       = 64;
  localparam int hist_w        = 8;
  localparam int table_index_w = 8;
  localparam int ras_depth     = 8;
  localparam int ctr_tables    = 3; // voting tables

  // derived address fields
  localparam int offset_w  = $clog2(block_bytes);
  localparam int set_w     = $clog2(tb_sets);
  localparam int tag_lsb   = offset_w + set_w;
  localparam int tag_w     = addr_w - tag_lsb;
  localparam int ras_ptr_w = $clog2(ras_depth);

  typedef logic [addr_w-1:0]        addr_t;
  typedef logic [hist_w-1:0]        hist_t;
  typedef logic [table_index_w-1:0] tindex_t;
  typedef logic [1:0]               ctr_t;
  typedef logic [ras_ptr_w-1:0]     ras_ptr_t;
  typedef logic [set_w-1:0]         tb_set_t;
  typedef logic [tag_w-1:0]         tb_tag_t;

  localparam addr_t reset_vector = 32'h0000_1000;
  localparam addr_t block_step   = addr_t'(block_bytes);
  localparam addr_t block_mask   = ~(block_step - 1'b1);
  localparam ctr_t  ctr_init     = 2'b01; // weakly not taken

  typedef enum logic [1:0] {
    kind_cond,
    kind_jump,
    kind_call,
    kind_ret
  } branch_kind_e;

  typedef struct packed {
    logic         valid;
    tb_tag_t      tag;
    addr_t        target;
    branch_kind_e kind;
  } tb_entry_t;

  typedef struct packed {
    addr_t addr;
    logic  taken;
    logic  slot;
    hist_t hist;   // before this block's shift
  } fetch_out_t;

  typedef struct packed {
    logic         valid;
    addr_t        src;
    logic         slot;
    branch_kind_e kind;
    addr_t        target;
    logic         taken;
    hist_t        hist;
    logic         mispredict;
  } retire_upd_t;

  typedef struct packed {
    logic [1:0]         hit;
    branch_kind_e [1:0] kind;
    addr_t [1:0]        target;
  } tb_hit_t;

endpackage
